// File: Makefile
# Verilator build and run of the uart to spi command path testbench

VERILATOR ?= verilator
TOP       ?= tb_slm_cmd
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_LINE ?= ** PASS **

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_LINE"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF -- '$(PASS_LINE)'

clean:
	rm -rf $(OBJ_DIR)

// File: design/frame_assembler.sv
// byte pairing into address/data spi frames and spi start handshake
`timescale 1ns/1ps

module frame_assembler import slm_cmd_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       rx_valid_i,
  input  byte_t      rx_byte_i,
  input  logic       spi_busy_i,
  output logic       spi_start_o,
  output spi_frame_t spi_frame_o
);

  // address/data chain, older byte moves up into the address
  byte_t addr_byte;
  byte_t data_byte;

  // high when the next byte completes a pair
  logic odd_byte;
  // frame waiting for the spi master
  logic pending;

  ////////////////////////////////////////////////////////////
  // pairing and pending flag
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      // expect an address byte first
      odd_byte <= 1'b0;
      pending  <= 1'b0;
    end else begin
      if (spi_start_o) begin
        pending <= 1'b0;
      end
      if (rx_valid_i) begin
        odd_byte <= ~odd_byte;
        // every second byte closes a frame
        if (odd_byte) begin
          pending <= 1'b1;
        end
      end
    end
  end

  // byte chain shifts on every received byte
  always_ff @(posedge fpga_clk) begin
    if (rx_valid_i) begin
      addr_byte <= data_byte;
      data_byte <= rx_byte_i;
    end
  end

  // fire as soon as the master is free
  assign spi_start_o = pending & ~spi_busy_i;
  assign spi_frame_o = {addr_byte, data_byte};

  // start only into an idle master, which then goes busy
  a_start_handshake: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    spi_start_o |-> !spi_busy_i ##1 spi_busy_i);

endmodule

// File: design/reset_stretch.sv
// reset command stretcher driving the active-low display reset
`timescale 1ns/1ps

module reset_stretch import slm_cmd_pkg::*; (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  output logic slm_reset_n_o
);

  // cycles left of the hold after the command drops
  logic [RESET_CNT_W-1:0] hold_cnt;

  // reload while commanded, then count down to zero
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      hold_cnt <= RESET_CNT_W'(RESET_HOLD_CYCLES);
    end else if (hold_cnt != '0) begin
      hold_cnt <= hold_cnt - 1'b1;
    end
  end

  // display needs a minimum reset width, low while either holds
  assign slm_reset_n_o = ~(reset_all_cmd_w | (hold_cnt != '0));

endmodule

// File: design/slm_cmd_pkg.sv
// command path types, widths, uart/spi timing constants and fsm state enums
package slm_cmd_pkg;

  ////////////////////////////////////////////////////////////
  // data widths
  ////////////////////////////////////////////////////////////

  // one uart byte, also one spi address or data byte
  typedef logic [7:0] byte_t;
  // spi frame, address in upper byte and data in lower byte
  typedef logic [15:0] spi_frame_t;
  // bit period counter shared by uart rx and tx
  typedef logic [7:0] baud_cnt_t;

  ////////////////////////////////////////////////////////////
  // timing
  ////////////////////////////////////////////////////////////

  // fpga_clk cycles per uart bit, short value for simulation
  // board runs 543 at 62.5 MHz for 115200 baud
  localparam int UART_CLKS_PER_BIT = 16;
  // last count of a full bit and of half a bit
  localparam baud_cnt_t BAUD_LAST = baud_cnt_t'(UART_CLKS_PER_BIT - 1);
  localparam baud_cnt_t BAUD_HALF = baud_cnt_t'(UART_CLKS_PER_BIT / 2 - 1);

  // sck half period in fpga_clk cycles
  localparam int SPI_HALF_PERIOD = 4;
  localparam int SPI_FRAME_BITS  = 16;
  localparam int SPI_HALF_CNT_W  = $clog2(SPI_HALF_PERIOD + 1);
  localparam int SPI_BIT_CNT_W   = $clog2(SPI_FRAME_BITS);

  // display reset hold after the reset command drops
  localparam int RESET_HOLD_CYCLES = 10;
  localparam int RESET_CNT_W       = $clog2(RESET_HOLD_CYCLES + 1);

  ////////////////////////////////////////////////////////////
  // state machines
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_e;
  typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_e;
  // low and high halves of each sck period
  typedef enum logic [1:0] {SPI_IDLE, SPI_LOW, SPI_HIGH, SPI_DONE} spi_state_e;

endpackage

// File: design/slm_cmd_top.sv
// top level of the uart to spi command path and the display reset stretcher
`timescale 1ns/1ps

module slm_cmd_top import slm_cmd_pkg::*; (
  input  logic fpga_clk,
  input  logic reset_all_cmd_w,
  input  logic uart_rx_i,
  output logic uart_tx_o,
  output logic spi_sck_o,
  output logic spi_cs_n_o,
  output logic spi_mosi_o,
  input  logic spi_miso_i,
  output logic slm_reset_n_o
);

  ////////////////////////////////////////////////////////////
  // stage to stage signals
  ////////////////////////////////////////////////////////////

  // uart rx to pairing
  logic       rx_valid;
  byte_t      rx_byte;
  // pairing to spi
  logic       spi_start;
  logic       spi_busy;
  spi_frame_t spi_frame;
  // spi response back to the host
  logic       rsp_valid;
  byte_t      rsp_byte;

  uart_rx u_uart_rx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .rx_valid_o      (rx_valid),
    .rx_byte_o       (rx_byte)
  );

  frame_assembler u_frame_assembler (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rx_valid_i      (rx_valid),
    .rx_byte_i       (rx_byte),
    .spi_busy_i      (spi_busy),
    .spi_start_o     (spi_start),
    .spi_frame_o     (spi_frame)
  );

  spi_master u_spi_master (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .spi_start_i     (spi_start),
    .spi_frame_i     (spi_frame),
    .spi_busy_o      (spi_busy),
    .spi_sck_o       (spi_sck_o),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_miso_i      (spi_miso_i),
    .rsp_valid_o     (rsp_valid),
    .rsp_byte_o      (rsp_byte)
  );

  uart_tx u_uart_tx (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .rsp_valid_i     (rsp_valid),
    .rsp_byte_i      (rsp_byte),
    .uart_tx_o       (uart_tx_o)
  );

  // display reset, beside the pipeline
  reset_stretch u_reset_stretch (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .slm_reset_n_o   (slm_reset_n_o)
  );

endmodule

// File: design/spi_master.sv
// spi mode 0 master, 16-bit frames, msb first, response byte capture
`timescale 1ns/1ps

module spi_master import slm_cmd_pkg::*; (
  input  logic       fpga_clk,
  input  logic       reset_all_cmd_w,
  input  logic       spi_start_i,
  input  spi_frame_t spi_frame_i,
  output logic       spi_busy_o,
  output logic       spi_sck_o,
  output logic       spi_cs_n_o,
  output logic       spi_mosi_o,
  input  logic       spi_miso_i,
  output logic       rsp_valid_o,
  output byte_t      rsp_byte_o
);

  spi_state_e                state;
  logic [SPI_HALF_CNT_W-1:0] half_cnt;
  logic [SPI_BIT_CNT_W-1:0]  bit_cnt;
  spi_frame_t                tx_shift;
  spi_frame_t                rx_shift;

  logic half_end;
  logic last_bit;

  assign half_end = (half_cnt == SPI_HALF_CNT_W'(SPI_HALF_PERIOD - 1));
  assign last_bit = (bit_cnt == SPI_BIT_CNT_W'(SPI_FRAME_BITS - 1));

  ////////////////////////////////////////////////////////////
  // sck, cs and handshake
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state       <= SPI_IDLE;
      half_cnt    <= '0;
      bit_cnt     <= '0;
      spi_sck_o   <= 1'b0;
      spi_cs_n_o  <= 1'b1;
      spi_busy_o  <= 1'b0;
      rsp_valid_o <= 1'b0;
    end else begin
      rsp_valid_o <= 1'b0;
      case (state)
        SPI_IDLE: begin
          if (spi_start_i) begin
            // cs drops one cycle after start
            spi_cs_n_o <= 1'b0;
            spi_busy_o <= 1'b1;
            half_cnt   <= '0;
            bit_cnt    <= '0;
            state      <= SPI_LOW;
          end
        end
        SPI_LOW: begin
          if (half_end) begin
            // rising edge, miso sampled below
            half_cnt  <= '0;
            spi_sck_o <= 1'b1;
            state     <= SPI_HIGH;
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        SPI_HIGH: begin
          if (half_end) begin
            half_cnt  <= '0;
            spi_sck_o <= 1'b0;
            if (last_bit) begin
              // cs rises half a period after the last rising edge
              spi_cs_n_o <= 1'b1;
              state      <= SPI_DONE;
            end else begin
              bit_cnt <= bit_cnt + 1'b1;
              state   <= SPI_LOW;
            end
          end else begin
            half_cnt <= half_cnt + 1'b1;
          end
        end
        SPI_DONE: begin
          rsp_valid_o <= 1'b1;
          spi_busy_o  <= 1'b0;
          state       <= SPI_IDLE;
        end
        default: state <= SPI_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // shift registers
  ////////////////////////////////////////////////////////////

  // mosi advances on the falling edge
  always_ff @(posedge fpga_clk) begin
    if (state == SPI_IDLE && spi_start_i) begin
      tx_shift <= spi_frame_i;
    end else if (state == SPI_HIGH && half_end && !last_bit) begin
      tx_shift <= {tx_shift[SPI_FRAME_BITS-2:0], 1'b0};
    end
  end

  // miso captured with the rising edge
  always_ff @(posedge fpga_clk) begin
    if (state == SPI_LOW && half_end) begin
      rx_shift <= {rx_shift[SPI_FRAME_BITS-2:0], spi_miso_i};
    end
  end

  assign spi_mosi_o = tx_shift[SPI_FRAME_BITS-1];
  // display answers during the data byte
  assign rsp_byte_o = rx_shift[7:0];

  // every sck transition happens inside an open chip select
  a_sck_in_cs: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    !$stable(spi_sck_o) |-> $past(spi_cs_n_o) == 1'b0);

endmodule

// File: design/uart_rx.sv
// uart 8N1 receiver with input synchronizer and one-cycle byte strobe
`timescale 1ns/1ps

module uart_rx import slm_cmd_pkg::*; (
  input  logic  fpga_clk,
  input  logic  reset_all_cmd_w,
  input  logic  uart_rx_i,
  output logic  rx_valid_o,
  output byte_t rx_byte_o
);

  // two flop synchronizer on the async serial line
  logic rx_meta;
  logic rx_sync;

  uart_rx_state_e state;
  baud_cnt_t      baud_cnt;
  logic [2:0]     bit_idx;
  byte_t          rx_shift;

  logic bit_tick;
  assign bit_tick = (baud_cnt == BAUD_LAST);

  ////////////////////////////////////////////////////////////
  // control fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      rx_meta    <= 1'b1;
      rx_sync    <= 1'b1;
      state      <= RX_IDLE;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      rx_valid_o <= 1'b0;
    end else begin
      rx_meta    <= uart_rx_i;
      rx_sync    <= rx_meta;
      // strobe only lasts one cycle
      rx_valid_o <= 1'b0;
      case (state)
        RX_IDLE: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          // falling edge marks a start bit
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // recheck in the middle of the start bit
          if (baud_cnt == BAUD_HALF) begin
            baud_cnt <= '0;
            state    <= rx_sync ? RX_IDLE : RX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_DATA: begin
          if (bit_tick) begin
            baud_cnt <= '0;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        RX_STOP: begin
          if (bit_tick) begin
            state      <= RX_IDLE;
            // low stop bit means framing error, no strobe
            rx_valid_o <= rx_sync;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  // lsb first, so new bits enter at the top
  always_ff @(posedge fpga_clk) begin
    if (state == RX_DATA && bit_tick) begin
      rx_shift <= {rx_sync, rx_shift[7:1]};
    end
  end

  assign rx_byte_o = rx_shift;

endmodule

// File: design/uart_tx.sv
// uart 8N1 transmitter with one-byte holding register for spi responses
`timescale 1ns/1ps

module uart_tx import slm_cmd_pkg::*; (
  input  logic  fpga_clk,
  input  logic  reset_all_cmd_w,
  input  logic  rsp_valid_i,
  input  byte_t rsp_byte_i,
  output logic  uart_tx_o
);

  uart_tx_state_e state;
  baud_cnt_t      baud_cnt;
  logic [2:0]     bit_idx;
  byte_t          tx_shift;

  // one byte waiting behind the one in flight
  byte_t hold_byte;
  logic  hold_valid;

  logic bit_tick;
  assign bit_tick = (baud_cnt == BAUD_LAST);

  ////////////////////////////////////////////////////////////
  // serializer fsm
  ////////////////////////////////////////////////////////////
  always_ff @(posedge fpga_clk) begin
    if (reset_all_cmd_w) begin
      state      <= TX_IDLE;
      baud_cnt   <= '0;
      bit_idx    <= '0;
      hold_valid <= 1'b0;
      // line idles high
      uart_tx_o  <= 1'b1;
    end else begin
      case (state)
        TX_IDLE: begin
          baud_cnt <= '0;
          bit_idx  <= '0;
          if (hold_valid) begin
            tx_shift   <= hold_byte;
            hold_valid <= 1'b0;
            uart_tx_o  <= 1'b0;
            state      <= TX_START;
          end else if (rsp_valid_i) begin
            tx_shift  <= rsp_byte_i;
            uart_tx_o <= 1'b0;
            state     <= TX_START;
          end
        end
        TX_START: begin
          if (bit_tick) begin
            baud_cnt  <= '0;
            uart_tx_o <= tx_shift[0];
            state     <= TX_DATA;
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        TX_DATA: begin
          if (bit_tick) begin
            baud_cnt <= '0;
            if (bit_idx == 3'd7) begin
              uart_tx_o <= 1'b1;
              state     <= TX_STOP;
            end else begin
              // lsb first
              tx_shift  <= {1'b0, tx_shift[7:1]};
              uart_tx_o <= tx_shift[1];
              bit_idx   <= bit_idx + 1'b1;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        TX_STOP: begin
          if (bit_tick) begin
            baud_cnt <= '0;
            bit_idx  <= '0;
            // held byte goes straight after the stop bit
            if (hold_valid) begin
              tx_shift   <= hold_byte;
              hold_valid <= 1'b0;
              uart_tx_o  <= 1'b0;
              state      <= TX_START;
            end else begin
              state <= TX_IDLE;
            end
          end else begin
            baud_cnt <= baud_cnt + 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
      // busy, so park the response
      if (rsp_valid_i && state != TX_IDLE) begin
        hold_byte  <= rsp_byte_i;
        hold_valid <= 1'b1;
      end
    end
  end

  // spi responses come slower than uart can drain them
  a_hold_free: assert property (@(posedge fpga_clk) disable iff (reset_all_cmd_w)
    rsp_valid_i |-> !hold_valid);

endmodule

// File: project.f
design/slm_cmd_pkg.sv
design/uart_rx.sv
design/frame_assembler.sv
design/spi_master.sv
design/uart_tx.sv
design/reset_stretch.sv
design/slm_cmd_top.sv
tests/tb_slm_cmd.sv

// File: tests/tb_slm_cmd.sv
// testbench for slm_cmd_top with uart driver, spi slave model, uart monitor and watchdog
`timescale 1ns/1ps

module tb_slm_cmd import slm_cmd_pkg::*; ();

  ////////////////////////////////////////////////////////////
  // constants
  ////////////////////////////////////////////////////////////

  localparam int CLK_PERIOD_NS = 8;
  localparam int RESET_CYCLES  = 16;
  // bytes sent over all tests, sets the watchdog
  localparam int TOTAL_BYTES   = 79;
  localparam int WATCHDOG_NS   = TOTAL_BYTES * 30 * UART_CLKS_PER_BIT * CLK_PERIOD_NS * 2;
  // wait limit for outstanding responses
  localparam int RSP_TIMEOUT   = 60 * UART_CLKS_PER_BIT;
  localparam byte_t RSP_MASK   = 8'h5A;

  logic fpga_clk;
  logic reset_all_cmd_w;
  logic uart_rx_i;
  logic uart_tx_o;
  logic spi_sck_o;
  logic spi_cs_n_o;
  logic spi_mosi_o;
  logic spi_miso_i;
  logic slm_reset_n_o;

  // lfsr state for random bytes and gaps
  logic [31:0] lfsr_state = 32'h3ec2_03f1;

  // pairing model
  byte_t last_byte;
  logic  pair_odd;

  // expected and observed traffic
  spi_frame_t exp_frame_q[$];
  byte_t      exp_rsp_q[$];
  spi_frame_t got_frame_q[$];
  byte_t      got_rsp_q[$];

  int cs_falls;
  int test_errors;
  int tests_passed;
  int tests_failed;

  slm_cmd_top dut0 (
    .fpga_clk        (fpga_clk),
    .reset_all_cmd_w (reset_all_cmd_w),
    .uart_rx_i       (uart_rx_i),
    .uart_tx_o       (uart_tx_o),
    .spi_sck_o       (spi_sck_o),
    .spi_cs_n_o      (spi_cs_n_o),
    .spi_mosi_o      (spi_mosi_o),
    .spi_miso_i      (spi_miso_i),
    .slm_reset_n_o   (slm_reset_n_o)
  );

  initial fpga_clk = 1'b0;
  always #4 fpga_clk = ~fpga_clk;

  ////////////////////////////////////////////////////////////
  // random numbers and uart driver
  ////////////////////////////////////////////////////////////

  // fibonacci lfsr with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  // one uart bit driven 1 ns after the edge
  task automatic drive_bit(input logic v);
    @(posedge fpga_clk);
    #1;
    uart_rx_i = v;
    repeat (UART_CLKS_PER_BIT - 1) @(posedge fpga_clk);
  endtask

  // 8N1 byte after a random idle gap, then update the pairing model
  task automatic send_byte(input byte_t b);
    int    gap;
    byte_t sh;
    gap = int'(rand_bits(3));
    sh  = b;
    repeat (gap * UART_CLKS_PER_BIT) @(posedge fpga_clk);
    drive_bit(1'b0);
    for (int i = 0; i < 8; i++) begin
      drive_bit(sh[0]);
      sh = sh >> 1;
    end
    drive_bit(1'b1);
    // second byte of a pair closes a frame
    if (pair_odd) begin
      exp_frame_q.push_back({last_byte, b});
      exp_rsp_q.push_back(last_byte ^ RSP_MASK);
    end
    pair_odd  = ~pair_odd;
    last_byte = b;
  endtask

  task automatic send_random(input int count);
    for (int i = 0; i < count; i++) begin
      send_byte(byte_t'(rand_bits(8)));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // result handling
  ////////////////////////////////////////////////////////////

  task automatic wait_responses(input string name);
    int cycles;
    cycles = 0;
    while (got_rsp_q.size() < exp_rsp_q.size() && cycles < RSP_TIMEOUT) begin
      @(posedge fpga_clk);
      cycles++;
    end
    if (got_rsp_q.size() < exp_rsp_q.size()) begin
      $display("%s: timed out waiting for responses, %0d of %0d arrived",
               name, got_rsp_q.size(), exp_rsp_q.size());
      test_errors++;
    end
    // quiet time catches stray frames or bytes
    repeat (20 * UART_CLKS_PER_BIT) @(posedge fpga_clk);
  endtask

  task automatic compare_queues(input string name);
    spi_frame_t ef;
    spi_frame_t gf;
    byte_t      er;
    byte_t      gr;
    if (got_frame_q.size() != exp_frame_q.size()) begin
      $display("MISMATCH %s frame count expected %0d actual %0d",
               name, exp_frame_q.size(), got_frame_q.size());
      test_errors++;
    end
    while (exp_frame_q.size() > 0 && got_frame_q.size() > 0) begin
      ef = exp_frame_q.pop_front();
      gf = got_frame_q.pop_front();
      if (gf !== ef) begin
        $display("MISMATCH %s frame expected %h actual %h", name, ef, gf);
        test_errors++;
      end
    end
    if (got_rsp_q.size() != exp_rsp_q.size()) begin
      $display("MISMATCH %s response count expected %0d actual %0d",
               name, exp_rsp_q.size(), got_rsp_q.size());
      test_errors++;
    end
    while (exp_rsp_q.size() > 0 && got_rsp_q.size() > 0) begin
      er = exp_rsp_q.pop_front();
      gr = got_rsp_q.pop_front();
      if (gr !== er) begin
        $display("MISMATCH %s response expected %h actual %h", name, er, gr);
        test_errors++;
      end
    end
    exp_frame_q.delete();
    got_frame_q.delete();
    exp_rsp_q.delete();
    got_rsp_q.delete();
  endtask

  task automatic finish_test(input string name);
    if (test_errors == 0) begin
      $display("test %s: ok", name);
      tests_passed++;
    end else begin
      $display("test %s: %0d errors", name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // counts low cycles of the display reset once the command has dropped
  task automatic measure_hold(input string name);
    int low_cycles;
    low_cycles = 0;
    while (slm_reset_n_o === 1'b0 && low_cycles <= 4 * RESET_HOLD_CYCLES) begin
      if ({spi_cs_n_o, spi_sck_o, uart_tx_o} !== 3'b101) begin
        $display("MISMATCH %s cs/sck/tx expected 101 actual %b",
                 name, {spi_cs_n_o, spi_sck_o, uart_tx_o});
        test_errors++;
      end
      low_cycles++;
      @(posedge fpga_clk);
      #1;
    end
    if (low_cycles != RESET_HOLD_CYCLES) begin
      $display("MISMATCH %s reset hold cycles expected %0d actual %0d",
               name, RESET_HOLD_CYCLES, low_cycles);
      test_errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // spi slave model
  ////////////////////////////////////////////////////////////

  // edges seen one cycle late while mosi is stable through the high half
  initial begin : spi_slave
    logic       cs_q;
    logic       sck_q;
    spi_frame_t mosi_sr;
    byte_t      rsp_sr;
    int         rises;
    cs_q       = 1'b1;
    sck_q      = 1'b0;
    mosi_sr    = '0;
    rsp_sr     = '0;
    rises      = 0;
    spi_miso_i = 1'b0;
    forever begin
      @(posedge fpga_clk);
      if (reset_all_cmd_w) begin
        cs_q  = 1'b1;
        sck_q = 1'b0;
        rises = 0;
      end else begin
        if (cs_q && !spi_cs_n_o) begin
          rises   = 0;
          mosi_sr = '0;
          cs_falls++;
        end
        if (!sck_q && spi_sck_o) begin
          if (spi_cs_n_o) begin
            $display("SCK rose while spi_cs_n_o was high");
            test_errors++;
          end else begin
            mosi_sr = {mosi_sr[14:0], spi_mosi_o};
            rises++;
            // answer to the address byte
            if (rises == 8) begin
              rsp_sr = mosi_sr[7:0] ^ RSP_MASK;
            end
          end
        end
        // response bits on falling edges, msb first
        if (sck_q && !spi_sck_o && !spi_cs_n_o && rises >= 8 && rises < 16) begin
          spi_miso_i <= #1 rsp_sr[7];
          rsp_sr = {rsp_sr[6:0], 1'b0};
        end
        if (!cs_q && spi_cs_n_o) begin
          if (rises != 16) begin
            $display("SPI frame had %0d SCK rising edges instead of 16", rises);
            test_errors++;
          end
          got_frame_q.push_back(mosi_sr);
        end
        cs_q  = spi_cs_n_o;
        sck_q = spi_sck_o;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // uart monitor
  ////////////////////////////////////////////////////////////

  initial begin : tx_monitor
    byte_t rx;
    rx = '0;
    forever begin
      @(posedge fpga_clk);
      if (!reset_all_cmd_w && uart_tx_o === 1'b0) begin
        // middle of the start bit
        repeat (UART_CLKS_PER_BIT / 2) @(posedge fpga_clk);
        if (uart_tx_o !== 1'b0) begin
          $display("start bit on uart_tx_o did not stay low");
          test_errors++;
        end
        // lsb first
        for (int i = 0; i < 8; i++) begin
          repeat (UART_CLKS_PER_BIT) @(posedge fpga_clk);
          rx = {uart_tx_o, rx[7:1]};
        end
        repeat (UART_CLKS_PER_BIT) @(posedge fpga_clk);
        if (uart_tx_o !== 1'b1) begin
          $display("stop bit on uart_tx_o was not high");
          test_errors++;
        end
        got_rsp_q.push_back(rx);
      end
    end
  end

  // hard limit on run time
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////
  initial begin : main
    int cs_before;
    reset_all_cmd_w = 1'b1;
    uart_rx_i       = 1'b1;
    pair_odd        = 1'b0;
    last_byte       = '0;
    cs_falls        = 0;
    test_errors     = 0;
    tests_passed    = 0;
    tests_failed    = 0;

    // idle outputs and display reset during and after reset
    repeat (RESET_CYCLES) begin
      @(posedge fpga_clk);
      #1;
      if ({spi_cs_n_o, spi_sck_o, uart_tx_o, slm_reset_n_o} !== 4'b1010) begin
        $display("MISMATCH reset_state cs/sck/tx/rst_n expected 1010 actual %b",
                 {spi_cs_n_o, spi_sck_o, uart_tx_o, slm_reset_n_o});
        test_errors++;
      end
    end
    reset_all_cmd_w = 1'b0;
    measure_hold("reset_state");
    finish_test("reset_state");

    // two bytes give one frame
    send_random(2);
    wait_responses("frame_content");
    compare_queues("frame_content");
    finish_test("frame_content");

    // lone byte must not start a frame
    cs_before = cs_falls;
    send_random(1);
    repeat (40 * UART_CLKS_PER_BIT) @(posedge fpga_clk);
    if (cs_falls != cs_before) begin
      $display("a SPI frame started after a single byte");
      test_errors++;
    end
    send_random(1);
    wait_responses("pairing_rule");
    compare_queues("pairing_rule");
    finish_test("pairing_rule");

    // several frames, responses in order
    send_random(8);
    wait_responses("response_return");
    compare_queues("response_return");
    finish_test("response_return");

    send_random(64);
    wait_responses("random_stream");
    compare_queues("random_stream");
    finish_test("random_stream");

    // reset between the two bytes of a pair
    send_random(1);
    repeat (2 * UART_CLKS_PER_BIT) @(posedge fpga_clk);
    #1;
    reset_all_cmd_w = 1'b1;
    pair_odd        = 1'b0;
    repeat (4) begin
      @(posedge fpga_clk);
      #1;
      if (slm_reset_n_o !== 1'b0) begin
        $display("MISMATCH reset_mid_stream slm_reset_n_o expected 0 actual %b",
                 slm_reset_n_o);
        test_errors++;
      end
    end
    reset_all_cmd_w = 1'b0;
    measure_hold("reset_mid_stream");
    send_random(2);
    wait_responses("reset_mid_stream");
    compare_queues("reset_mid_stream");
    finish_test("reset_mid_stream");

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule
